//--- verilog/read_datapath_settings.svh
// Fixed for a two-group half-rate DDR3 read path; FIFO depth must not exceed 2**RD_FIFO_AW
`ifndef READ_DATAPATH_SETTINGS_SVH
`define READ_DATAPATH_SETTINGS_SVH

// ****************************************************************************
// Interface geometry
// ****************************************************************************

// Read DQS groups on the interface
`define RD_DQS_GROUPS 2
// DQ bits captured by one DQS group
`define RD_DQ_PER_GROUP 8
// Half rate gives four memory time slots per AFI clock
`define RD_SLOTS 4

// ****************************************************************************
// Resynchronisation FIFO and latency shifter
// ****************************************************************************

// Entries per group FIFO, and the pointer width that addresses them
`define RD_FIFO_DEPTH 8
`define RD_FIFO_AW 3
// Length of the read-enable history, so the largest usable latency is 31
`define RD_MAX_LATENCY 32
`define RD_LAT_CNT_W 5

// ****************************************************************************
// Termination override window
// ****************************************************************************

// Memory read latency in memory clocks
`define RD_MEM_T_RL 7
// Window start is (RD_MEM_T_RL - 4) / 2 when RD_MEM_T_RL > 4, else 0
`define RD_OCT_ON_DELAY 1
// Window end is (RD_MEM_T_RL + 6) / 2, counted in AFI cycles
`define RD_OCT_OFF_DELAY 6

`endif

//--- verilog/read_datapath_pkg.sv
// Word layouts assume the geometry in the settings header; no run-time resizing is possible
`include "read_datapath_settings.svh"

package read_datapath_pkg;

	// One DQS group's bits in one time slot
	typedef logic [`RD_DQ_PER_GROUP-1:0] dq_group_t;

	// All time slots of one group, slot 0 in the lowest byte
	typedef dq_group_t [`RD_SLOTS-1:0] group_word_t;

	// A full AFI word; the same shape is used slot-major on the AFI side
	// and group-major on the DDIO and sequencer sides
	typedef dq_group_t [`RD_SLOTS*`RD_DQS_GROUPS-1:0] afi_word_t;

	// Read latency select from the sequencer
	typedef logic [`RD_LAT_CNT_W-1:0] lat_cnt_t;

	// Pointer into one resynchronisation FIFO
	typedef logic [`RD_FIFO_AW-1:0] fifo_addr_t;

	// History of read-enable requests, bit 0 is the most recent
	typedef logic [`RD_MAX_LATENCY-1:0] lat_hist_t;

	// Request history for the termination window, bit 0 is the live request
	typedef logic [`RD_OCT_OFF_DELAY:0] oct_hist_t;

endpackage

//--- verilog/read_capture_group.sv
// Single clock domain; a capture on the cycle after a sequencer FIFO reset writes a stale address
`timescale 1ns/1ns
`include "read_datapath_settings.svh"

module read_capture_group
(
	input  logic                           pll_afi_clk,
	input  logic                           reset_n_afi_clk,
	input  logic                           capture_valid_i,
	input  logic                           seq_read_fifo_reset_i,
	input  read_datapath_pkg::group_word_t ddio_group_i,
	output logic                           wr_en_o,
	output read_datapath_pkg::fifo_addr_t  wr_addr_o,
	output read_datapath_pkg::group_word_t wr_data_o
);

	import read_datapath_pkg::*;

	// Write-side copy of the sequencer FIFO reset
	logic fifo_reset_r;
	// Next entry to be written by a capture
	fifo_addr_t wr_ptr;

	// The sequencer reset reaches the write pointer one cycle after the
	// read pointer, so the write side sees it as a registered pulse
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			fifo_reset_r <= 1'b0;
		end
		else
		begin
			fifo_reset_r <= seq_read_fifo_reset_i;
		end
	end

	// Write pointer moves once per captured word and wraps at the FIFO depth
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
		end
		else if (fifo_reset_r)
		begin
			wr_ptr <= '0;
		end
		else if (capture_valid_i)
		begin
			wr_ptr <= (wr_ptr == fifo_addr_t'(`RD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		end
	end

	// The capture strobe is the write strobe, so a word sampled at an edge
	// is stored at that same edge
	assign wr_en_o   = capture_valid_i;
	assign wr_addr_o = wr_ptr;
	assign wr_data_o = ddio_group_i;

endmodule

//--- verilog/read_fifo_group.sv
// No full or empty detection; the sequencer must keep pops behind captures and within depth
`timescale 1ns/1ns
`include "read_datapath_settings.svh"

module read_fifo_group
(
	input  logic                           pll_afi_clk,
	input  logic                           reset_n_afi_clk,
	input  logic                           seq_read_fifo_reset_i,
	input  logic                           wr_en_i,
	input  read_datapath_pkg::fifo_addr_t  wr_addr_i,
	input  read_datapath_pkg::group_word_t wr_data_i,
	input  logic                           rd_en_i,
	output read_datapath_pkg::group_word_t rd_data_o
);

	import read_datapath_pkg::*;

	// Flop storage, one captured word per entry
	group_word_t fifo_mem [`RD_FIFO_DEPTH];
	// Next entry to be released to the AFI
	fifo_addr_t rd_ptr;

	// ************************************************************************
	// Write side
	// ************************************************************************

	// Address and strobe come from the capture group of the same DQS group
	always_ff @(posedge pll_afi_clk)
	begin
		if (wr_en_i)
		begin
			fifo_mem[wr_addr_i] <= wr_data_i;
		end
	end

	// ************************************************************************
	// Read side
	// ************************************************************************

	// The raw sequencer reset clears the read pointer at once, a cycle
	// ahead of the write pointer
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rd_ptr <= '0;
		end
		else if (seq_read_fifo_reset_i)
		begin
			rd_ptr <= '0;
		end
		else if (rd_en_i)
		begin
			rd_ptr <= (rd_ptr == fifo_addr_t'(`RD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	// Output register holds the last popped word until the next pop
	// This register lines up with the registered read valid
	always_ff @(posedge pll_afi_clk)
	begin
		if (rd_en_i)
		begin
			rd_data_o <= fifo_mem[rd_ptr];
		end
	end

endmodule

//--- verilog/read_latency_selector.sv
// Latency select must stay below RD_MAX_LATENCY and be stable while reads are in flight
`timescale 1ns/1ns
`include "read_datapath_settings.svh"

module read_latency_selector
(
	input  logic                        pll_afi_clk,
	input  logic                        reset_n_afi_clk,
	input  logic                        afi_rdata_en_full_i,
	input  read_datapath_pkg::lat_cnt_t seq_read_latency_counter_i,
	output logic                        read_enable_o,
	output logic                        afi_rdata_valid_o
);

	import read_datapath_pkg::*;

	// Bit n is set when a request was seen n+1 edges ago
	lat_hist_t latency_shifter;

	// ************************************************************************
	// Request history
	// ************************************************************************

	// One request per AFI cycle enters at bit 0 and ages by one per edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[`RD_MAX_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// ************************************************************************
	// Tap and valid
	// ************************************************************************

	// The tap picked by the sequencer is registered into the FIFO pop
	// A request at edge k pops all groups at edge k+L+2
	// The valid register sits beside the FIFO output registers, so data
	// and valid leave on the same edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_enable_o     <= 1'b0;
			afi_rdata_valid_o <= 1'b0;
		end
		else
		begin
			read_enable_o     <= latency_shifter[seq_read_latency_counter_i];
			afi_rdata_valid_o <= read_enable_o;
		end
	end

endmodule

//--- verilog/oct_window.sv
// Window bounds are fixed for RD_MEM_T_RL of 7; one override bit serves all DQS groups
`timescale 1ns/1ns
`include "read_datapath_settings.svh"

module oct_window
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic afi_rdata_en_full_i,
	output logic force_oct_off_o
);

	import read_datapath_pkg::*;

	// Past requests, bit 0 holds the request of the previous edge
	logic [`RD_OCT_OFF_DELAY-1:0] rdata_en_r;
	// Live request joined to its history, bit n is the request n edges back
	oct_hist_t rdata_en_shifter;

	assign rdata_en_shifter = {rdata_en_r, afi_rdata_en_full_i};

	// Termination stays enabled (override low) while any request between
	// the on and off delays is still in the history
	// Outside a read burst the override is high and termination is forced off
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r      <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_r      <= rdata_en_shifter[`RD_OCT_OFF_DELAY-1:0];
			force_oct_off_o <= ~(|rdata_en_shifter[`RD_OCT_OFF_DELAY:`RD_OCT_ON_DELAY]);
		end
	end

endmodule

//--- verilog/read_datapath.sv
// All groups pop together on one read enable; captures per group are free-running on their strobe
`timescale 1ns/1ns
`include "read_datapath_settings.svh"

module read_datapath
(
	input  logic                         pll_afi_clk,
	input  logic                         reset_n_afi_clk,
	input  read_datapath_pkg::afi_word_t ddio_phy_dq_i,
	input  logic [`RD_DQS_GROUPS-1:0]    capture_valid_i,
	input  logic [`RD_DQS_GROUPS-1:0]    seq_read_fifo_reset_i,
	input  logic                         afi_rdata_en_full_i,
	input  read_datapath_pkg::lat_cnt_t  seq_read_latency_counter_i,
	output read_datapath_pkg::afi_word_t afi_rdata_o,
	output read_datapath_pkg::afi_word_t phy_mux_read_fifo_q_o,
	output logic                         afi_rdata_valid_o,
	output logic                         force_oct_off_o
);

	import read_datapath_pkg::*;

	// Common pop strobe for every group FIFO
	logic read_enable;

	// ************************************************************************
	// Release timing
	// ************************************************************************

	read_latency_selector latency_sel_i
	(
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.read_enable_o              (read_enable),
		.afi_rdata_valid_o          (afi_rdata_valid_o)
	);

	oct_window oct_window_i
	(
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

	// ************************************************************************
	// Per-group capture and resynchronisation
	// ************************************************************************

	for (genvar g = 0; g < `RD_DQS_GROUPS; g++)
	begin : group_gen
		logic        wr_en;
		fifo_addr_t  wr_addr;
		group_word_t wr_data;
		group_word_t ddio_group;
		group_word_t rd_word;

		// DDIO bus is group-major: D1_T3 .. D1_T0, D0_T3 .. D0_T0
		// The AFI bus is slot-major: T3_D1, T3_D0 .. T0_D1, T0_D0
		// The sequencer copy keeps the group-major order of the DDIO bus
		for (genvar s = 0; s < `RD_SLOTS; s++)
		begin : slot_gen
			assign ddio_group[s]                           = ddio_phy_dq_i[g*`RD_SLOTS + s];
			assign afi_rdata_o[s*`RD_DQS_GROUPS + g]       = rd_word[s];
			assign phy_mux_read_fifo_q_o[g*`RD_SLOTS + s]  = rd_word[s];
		end

		read_capture_group capture_i
		(
			.pll_afi_clk           (pll_afi_clk),
			.reset_n_afi_clk       (reset_n_afi_clk),
			.capture_valid_i       (capture_valid_i[g]),
			.seq_read_fifo_reset_i (seq_read_fifo_reset_i[g]),
			.ddio_group_i          (ddio_group),
			.wr_en_o               (wr_en),
			.wr_addr_o             (wr_addr),
			.wr_data_o             (wr_data)
		);

		read_fifo_group fifo_i
		(
			.pll_afi_clk           (pll_afi_clk),
			.reset_n_afi_clk       (reset_n_afi_clk),
			.seq_read_fifo_reset_i (seq_read_fifo_reset_i[g]),
			.wr_en_i               (wr_en),
			.wr_addr_i             (wr_addr),
			.wr_data_i             (wr_data),
			.rd_en_i               (read_enable),
			.rd_data_o             (rd_word)
		);
	end

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running 8 ns clock; reset is released on a falling edge after 8 rising edges
`timescale 1ns/1ns

module tb_clock_gen
(
	output logic pll_afi_clk_o,
	output logic reset_n_afi_clk_o
);

	// Half of the 8 ns AFI clock period
	localparam int HALF_PERIOD_NS = 4;

	initial
	begin
		pll_afi_clk_o = 1'b0;
		forever #(HALF_PERIOD_NS) pll_afi_clk_o = ~pll_afi_clk_o;
	end

	// Reset is let go between edges so no flop sees it change at its clock
	initial
	begin
		reset_n_afi_clk_o = 1'b0;
		repeat (8) @(posedge pll_afi_clk_o);
		@(negedge pll_afi_clk_o);
		reset_n_afi_clk_o = 1'b1;
	end

endmodule

//--- testbench/read_datapath_props.sv
// Expects requests only while the latency select is steady and FIFO resets only when nothing is in flight
`timescale 1ns/1ns
`include "read_datapath_settings.svh"

module read_datapath_props
(
	input logic                         pll_afi_clk,
	input logic                         reset_n_afi_clk,
	input logic [`RD_DQS_GROUPS-1:0]    capture_valid_i,
	input logic [`RD_DQS_GROUPS-1:0]    seq_read_fifo_reset_i,
	input logic                         afi_rdata_en_full_i,
	input read_datapath_pkg::lat_cnt_t  seq_read_latency_counter_i,
	input logic                         read_enable,
	input read_datapath_pkg::afi_word_t afi_rdata_o,
	input read_datapath_pkg::afi_word_t phy_mux_read_fifo_q_o,
	input logic                         afi_rdata_valid_o,
	input logic                         force_oct_off_o
);

	import read_datapath_pkg::*;

	// Read by the testbench through the hierarchy
	int fail_count = 0;

	// Bit m holds the request sampled m+1 edges before the current one
	logic [`RD_MAX_LATENCY+1:0] req_hist;
	// Set once the outputs have seen one edge out of reset
	logic out_live;
	// Captures, pops and valids per group since the last FIFO reset
	int cap_cnt [`RD_DQS_GROUPS];
	int pop_cnt [`RD_DQS_GROUPS];
	int out_cnt [`RD_DQS_GROUPS];

	// Byte of lane (slot * groups + group) for capture number n
	function automatic logic [7:0] expected_byte(input int n, input int lane);
		return 8'((n + 32 * lane) & 255);
	endfunction

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			req_hist <= '0;
			out_live <= 1'b0;
			for (int g = 0; g < `RD_DQS_GROUPS; g++)
			begin
				cap_cnt[g] <= 0;
				pop_cnt[g] <= 0;
				out_cnt[g] <= 0;
			end
		end
		else
		begin
			req_hist <= {req_hist[`RD_MAX_LATENCY:0], afi_rdata_en_full_i};
			out_live <= 1'b1;
			for (int g = 0; g < `RD_DQS_GROUPS; g++)
			begin
				if (seq_read_fifo_reset_i[g])
				begin
					cap_cnt[g] <= 0;
					pop_cnt[g] <= 0;
					out_cnt[g] <= 0;
				end
				else
				begin
					cap_cnt[g] <= cap_cnt[g] + (capture_valid_i[g] ? 1 : 0);
					pop_cnt[g] <= pop_cnt[g] + (read_enable ? 1 : 0);
					out_cnt[g] <= out_cnt[g] + (afi_rdata_valid_o ? 1 : 0);
				end
			end
		end
	end

	// ************************************************************************
	// Reset, valid timing and termination window
	// ************************************************************************

	reset_quiet: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> (!afi_rdata_valid_o && !force_oct_off_o))
	else
	begin
		fail_count++;
		$error("Read valid or termination override is set while reset is held");
	end

	// Valid after edge k+L+2 follows the request at edge k
	valid_latency: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o == req_hist[int'(seq_read_latency_counter_i) + 2])
	else
	begin
		fail_count++;
		$error("mismatch at %0t: afi_rdata_valid_o got %b expected %b", $time,
			$sampled(afi_rdata_valid_o),
			$sampled(req_hist[int'(seq_read_latency_counter_i) + 2]));
	end

	// Override is low while a request sits one to six edges back
	oct_rule: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		out_live |-> force_oct_off_o == ~(|req_hist[`RD_OCT_OFF_DELAY:`RD_OCT_ON_DELAY]))
	else
	begin
		fail_count++;
		$error("mismatch at %0t: force_oct_off_o got %b expected %b", $time,
			$sampled(force_oct_off_o),
			$sampled(~(|req_hist[`RD_OCT_OFF_DELAY:`RD_OCT_ON_DELAY])));
	end

	// ************************************************************************
	// Data order and usage limits, per group
	// ************************************************************************

	for (genvar g = 0; g < `RD_DQS_GROUPS; g++)
	begin : group_chk
		for (genvar s = 0; s < `RD_SLOTS; s++)
		begin : slot_chk
			localparam int LANE = s * `RD_DQS_GROUPS + g;

			afi_data: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
				afi_rdata_valid_o |-> afi_rdata_o[LANE] == expected_byte(out_cnt[g], LANE))
			else
			begin
				fail_count++;
				$error("mismatch at %0t: afi_rdata_o lane %0d got %h expected %h", $time,
					LANE, $sampled(afi_rdata_o[LANE]),
					expected_byte($sampled(out_cnt[g]), LANE));
			end

			seq_data: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
				afi_rdata_valid_o |->
				phy_mux_read_fifo_q_o[g*`RD_SLOTS + s] == expected_byte(out_cnt[g], LANE))
			else
			begin
				fail_count++;
				$error("mismatch at %0t: phy_mux_read_fifo_q_o lane %0d got %h expected %h",
					$time, g*`RD_SLOTS + s, $sampled(phy_mux_read_fifo_q_o[g*`RD_SLOTS + s]),
					expected_byte($sampled(out_cnt[g]), LANE));
			end
		end

		no_underrun: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			read_enable |-> cap_cnt[g] > pop_cnt[g])
		else
		begin
			fail_count++;
			$error("Group %0d was popped with no captured word waiting", g);
		end

		no_overrun: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			capture_valid_i[g] |-> cap_cnt[g] - pop_cnt[g] < `RD_FIFO_DEPTH)
		else
		begin
			fail_count++;
			$error("Group %0d captured a word into a full FIFO", g);
		end
	end

endmodule

bind read_datapath read_datapath_props props_i
(
	.pll_afi_clk                (pll_afi_clk),
	.reset_n_afi_clk            (reset_n_afi_clk),
	.capture_valid_i            (capture_valid_i),
	.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
	.afi_rdata_en_full_i        (afi_rdata_en_full_i),
	.seq_read_latency_counter_i (seq_read_latency_counter_i),
	.read_enable                (read_enable),
	.afi_rdata_o                (afi_rdata_o),
	.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
	.afi_rdata_valid_o          (afi_rdata_valid_o),
	.force_oct_off_o            (force_oct_off_o)
);

//--- testbench/tb_read_datapath.sv
// Checking lives in the bound assertions; bursts never exceed the FIFO depth and drain before L changes
`timescale 1ns/1ns
`include "read_datapath_settings.svh"

module tb_read_datapath;

	import read_datapath_pkg::*;

	localparam int NUM_BURSTS = 20;
	// Worst burst is 8 captures, 8 requests with gaps of 3, latency 22 and a 34 cycle idle
	localparam int BURST_CYCLES = 120;
	localparam int WATCHDOG_NS = (8 + 40 + (NUM_BURSTS + 2) * BURST_CYCLES) * 8 + 1000;

	logic                      pll_afi_clk;
	logic                      reset_n_afi_clk;
	afi_word_t                 ddio_phy_dq_i;
	logic [`RD_DQS_GROUPS-1:0] capture_valid_i;
	logic [`RD_DQS_GROUPS-1:0] seq_read_fifo_reset_i;
	logic                      afi_rdata_en_full_i;
	lat_cnt_t                  seq_read_latency_counter_i;
	afi_word_t                 afi_rdata_o;
	afi_word_t                 phy_mux_read_fifo_q_o;
	logic                      afi_rdata_valid_o;
	logic                      force_oct_off_o;

	logic [31:0] rng_state = 32'h07930bb8;
	// Index of the next capture, shared by both groups
	int cap_n = 0;
	// Valids seen so far and valids that the requests so far will produce
	int valid_seen = 0;
	int valid_due = 0;
	int tests_run = 0;

	tb_clock_gen clock_gen_i
	(
		.pll_afi_clk_o     (pll_afi_clk),
		.reset_n_afi_clk_o (reset_n_afi_clk)
	);

	read_datapath dut_i
	(
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.capture_valid_i            (capture_valid_i),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.afi_rdata_o                (afi_rdata_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	// Valid is a one-cycle pulse per pop, so the falling edge counts each once
	always @(negedge pll_afi_clk)
	begin
		if (reset_n_afi_clk && afi_rdata_valid_o)
		begin
			valid_seen++;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Next random value in 0 .. range-1
	task automatic pick(input int range, output int value);
		rng_state = xorshift(rng_state);
		value = int'(rng_state % 32'(range));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge pll_afi_clk);
	endtask

	// One word per cycle on both groups, bytes laid out group-major
	task automatic capture_words(input int count);
		repeat (count)
		begin
			@(negedge pll_afi_clk);
			for (int g = 0; g < `RD_DQS_GROUPS; g++)
			begin
				for (int s = 0; s < `RD_SLOTS; s++)
				begin
					ddio_phy_dq_i[g*`RD_SLOTS + s] = 8'((cap_n + 32 * (s * 2 + g)) & 255);
				end
			end
			capture_valid_i = '1;
			cap_n++;
		end
		@(negedge pll_afi_clk);
		capture_valid_i = '0;
	endtask

	task automatic issue_requests(input int count);
		int gap;
		repeat (count)
		begin
			afi_rdata_en_full_i = 1'b1;
			valid_due++;
			@(negedge pll_afi_clk);
			afi_rdata_en_full_i = 1'b0;
			pick(4, gap);
			idle_cycles(gap);
		end
	endtask

	// The watchdog bounds this wait
	task automatic wait_valids();
		wait (valid_seen == valid_due);
	endtask

	// Words are captured first so a pop never overtakes its capture
	task automatic run_burst(input int len);
		capture_words(len);
		issue_requests(len);
		wait_valids();
		// Requests must age past every tap before the latency may change
		idle_cycles(`RD_MAX_LATENCY + 2);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("Test %s finished, failed checks so far %0d", name, dut_i.props_i.fail_count);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("Errors found");
		$finish;
	end

	initial
	begin
		int lat;
		int len;
		ddio_phy_dq_i              = '0;
		capture_valid_i            = '0;
		seq_read_fifo_reset_i      = '0;
		afi_rdata_en_full_i        = 1'b0;
		seq_read_latency_counter_i = '0;

		wait (reset_n_afi_clk);
		idle_cycles(20);
		report_test("reset_idle");

		// Random latency and burst shape, covering valid, data and window rules
		for (int b = 0; b < NUM_BURSTS; b++)
		begin
			pick(21, lat);
			pick(8, len);
			seq_read_latency_counter_i = lat_cnt_t'(lat);
			idle_cycles(2);
			run_burst(len + 1);
		end
		report_test("latency_bursts");

		// Leave a few words unpopped so the FIFO reset has stale entries to drop
		capture_words(3);

		// A FIFO reset restarts both pointers, so capture numbering restarts too
		seq_read_fifo_reset_i = '1;
		@(negedge pll_afi_clk);
		seq_read_fifo_reset_i = '0;
		idle_cycles(2);
		cap_n = 0;
		seq_read_latency_counter_i = lat_cnt_t'(3);
		idle_cycles(2);
		run_burst(8);
		report_test("fifo_reset");

		$display("Tests run %0d, failed checks %0d", tests_run, dut_i.props_i.fail_count);
		if (dut_i.props_i.fail_count == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+verilog
verilog/read_datapath_pkg.sv
verilog/read_capture_group.sv
verilog/read_fifo_group.sv
verilog/read_latency_selector.sv
verilog/oct_window.sv
verilog/read_datapath.sv
testbench/tb_clock_gen.sv
testbench/read_datapath_props.sv
testbench/tb_read_datapath.sv

//--- run_sim.sh
#!/bin/bash
# Builds and runs the read datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_read_datapath \
	-Mdir obj_dir -o sim_read_datapath \
	&& ./obj_dir/sim_read_datapath +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -qx "No errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
